/* bag_rx.sv */
`include "link_settings.svh"

module bag_rx #(
    parameter int BIT_CYCLES = `LINK_BIT_CYCLES
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx_line,
    input  logic                       fd_rx,
    output logic                       fs_rx,
    output link_pkg::bag_type_e        rx_btype,
    output logic [`LINK_DATA_BITS-1:0] rx_bdata
);

    localparam int CYC_W = $clog2(BIT_CYCLES + 1);
    localparam int SHIFT_BITS = `LINK_TYPE_BITS + `LINK_DATA_BITS;
    localparam int STOP_BIT = SHIFT_BITS + 1;

    logic                  sync1;
    logic                  sync2;
    logic                  line_q;
    logic                  busy;
    logic [CYC_W-1:0]      cyc_cnt;
    logic [3:0]            bit_cnt;
    logic [SHIFT_BITS-1:0] shreg;
    logic                  sample;
    logic                  take;

    assign sample = busy && (cyc_cnt == CYC_W'(BIT_CYCLES - 1));
    // good stop bit and the output side is free.
    assign take = sample && (bit_cnt == 4'(STOP_BIT)) && sync2 && !fs_rx && !fd_rx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync1  <= 1'b1;
            sync2  <= 1'b1;
            line_q <= 1'b1;
        end else begin
            sync1  <= rx_line;
            sync2  <= sync1;
            line_q <= sync2;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (line_q && !sync2) begin
                // half a bit in, so samples land mid-bit.
                busy    <= 1'b1;
                cyc_cnt <= CYC_W'(BIT_CYCLES / 2);
                bit_cnt <= '0;
            end
        end else if (sample) begin
            cyc_cnt <= '0;
            if (bit_cnt == 4'd0 && sync2) begin
                // start bit gone by mid-bit, a glitch.
                busy <= 1'b0;
            end else if (bit_cnt == 4'(STOP_BIT)) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // type first then data, both LSB first.
    always_ff @(posedge clk) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'(STOP_BIT)) begin
            shreg <= {sync2, shreg[SHIFT_BITS-1:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_rx <= 1'b0;
        end else if (take) begin
            fs_rx <= 1'b1;
        end else if (fs_rx && fd_rx) begin
            fs_rx <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rx_btype <= link_pkg::bag_type_e'(shreg[`LINK_TYPE_BITS-1:0]);
            rx_bdata <= shreg[SHIFT_BITS-1:`LINK_TYPE_BITS];
        end
    end

endmodule

/* bag_tx.sv */
`include "link_settings.svh"

module bag_tx #(
    parameter int BIT_CYCLES = `LINK_BIT_CYCLES
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                fs_tx,
    input  link_pkg::bag_type_e tx_btype,
    output logic                fd_tx,
    output logic                tx_line
);

    localparam int CYC_W = $clog2(BIT_CYCLES + 1);
    // start, type bits, stop.
    localparam int FRAME_BITS = `LINK_TYPE_BITS + 2;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_GUARD,
        TX_DONE
    } tx_state_e;

    tx_state_e              state;
    logic [CYC_W-1:0]       cyc_cnt;
    logic [2:0]             bit_cnt;
    logic [`LINK_TYPE_BITS:0] shreg;
    logic                   bit_end;

    assign bit_end = (cyc_cnt == CYC_W'(BIT_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            fd_tx   <= 1'b0;
            tx_line <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (fs_tx) begin
                        // start bit goes out at once.
                        tx_line <= 1'b0;
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (bit_end) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        tx_line <= shreg[0];
                        if (bit_cnt == 3'(FRAME_BITS - 1)) begin
                            state <= TX_GUARD;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                TX_GUARD: begin
                    fd_tx <= 1'b1;
                    state <= TX_DONE;
                end
                TX_DONE: begin
                    if (!fs_tx) begin
                        fd_tx <= 1'b0;
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // type bits LSB first, ones fill in behind as the stop level.
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && fs_tx) begin
            shreg <= {1'b1, tx_btype};
        end else if (state == TX_SHIFT && bit_end) begin
            shreg <= {1'b1, shreg[`LINK_TYPE_BITS:1]};
        end
    end

endmodule

/* compile.f */
+incdir+.
link_pkg.sv
bag_tx.sv
bag_rx.sv
link_cs.sv
link_top.sv
link_props.sv
link_tb.sv

/* link_cs.sv */
`include "link_settings.svh"

module link_cs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fs_send,
    input  link_pkg::bag_type_e        send_btype,
    output logic                       fd_send,
    output logic                       fs_read,
    input  logic                       fd_read,
    output link_pkg::bag_type_e        read_btype,
    output logic [`LINK_DATA_BITS-1:0] read_bdata,
    output logic [`LINK_DATA_BITS-1:0] device_idx,
    output logic [`LINK_DATA_BITS-1:0] data_idx,
    output logic                       fs_tx,
    input  logic                       fd_tx,
    output link_pkg::bag_type_e        tx_btype,
    input  logic                       fs_rx,
    output logic                       fd_rx,
    input  link_pkg::bag_type_e        rx_btype,
    input  logic [`LINK_DATA_BITS-1:0] rx_bdata
);

    link_pkg::cs_state_e state;
    link_pkg::cs_state_e next_state;
    link_pkg::cs_state_e state_goto;
    logic                read_ok;

    // peer bags that are taken and acknowledged.
    assign read_ok = (rx_btype == link_pkg::BAG_DIDX) ||
                     (rx_btype == link_pkg::BAG_DPARAM) ||
                     (rx_btype == link_pkg::BAG_DDIDX);

    assign fd_send = (state == link_pkg::SEND_DONE);
    assign fs_read = (state == link_pkg::READ_DONE);
    assign fs_tx   = (state == link_pkg::SEND_DATA) ||
                     (state == link_pkg::SEND_ACK) ||
                     (state == link_pkg::SEND_NAK);
    assign fd_rx   = (state == link_pkg::RECV_DONE) ||
                     (state == link_pkg::READ_WAIT) ||
                     (state == link_pkg::SEND_WNAK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= link_pkg::MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            link_pkg::MAIN_IDLE: next_state = link_pkg::MAIN_WAIT;
            link_pkg::MAIN_WAIT: begin
                if (fs_send) begin
                    next_state = link_pkg::SEND_PDATA0;
                end else if (fs_rx && !fd_read) begin
                    // host must have closed the last read first.
                    next_state = link_pkg::READ_DATA;
                end
            end
            link_pkg::SEND_PDATA0: next_state = link_pkg::SEND_DATA;
            link_pkg::SEND_PDATA1: next_state = link_pkg::SEND_DATA;
            link_pkg::SEND_DATA: begin
                if (fd_tx) next_state = link_pkg::RECV_WAIT;
            end
            link_pkg::RECV_WAIT: begin
                if (fs_rx) next_state = link_pkg::RECV_TAKE;
            end
            link_pkg::RECV_TAKE: next_state = link_pkg::RECV_DONE;
            link_pkg::RECV_DONE: begin
                if (!fs_rx) next_state = state_goto;
            end
            link_pkg::SEND_DONE: begin
                if (!fs_send) next_state = link_pkg::MAIN_WAIT;
            end
            link_pkg::READ_DATA: begin
                if (read_ok) begin
                    next_state = link_pkg::READ_TAKE;
                end else begin
                    next_state = link_pkg::SEND_WNAK;
                end
            end
            link_pkg::READ_TAKE: next_state = link_pkg::READ_WAIT;
            link_pkg::READ_WAIT: begin
                if (!fs_rx) next_state = link_pkg::SEND_PACK;
            end
            link_pkg::SEND_WNAK: begin
                if (!fs_rx) next_state = link_pkg::SEND_PNAK;
            end
            link_pkg::SEND_PACK: next_state = link_pkg::SEND_ACK;
            link_pkg::SEND_PNAK: next_state = link_pkg::SEND_NAK;
            link_pkg::SEND_ACK, link_pkg::SEND_NAK: begin
                if (fd_tx) next_state = link_pkg::READ_DONE;
            end
            link_pkg::READ_DONE: begin
                if (fd_read) next_state = link_pkg::MAIN_WAIT;
            end
            default: next_state = link_pkg::MAIN_IDLE;
        endcase
    end

    // where to go once the peer answer is released.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_goto <= link_pkg::MAIN_IDLE;
        end else if (state == link_pkg::RECV_TAKE) begin
            case (rx_btype)
                link_pkg::BAG_ACK: state_goto <= link_pkg::SEND_DONE;
                link_pkg::BAG_NAK: state_goto <= link_pkg::SEND_PDATA1;
                default:           state_goto <= link_pkg::MAIN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_btype <= link_pkg::BAG_INIT;
            read_bdata <= '0;
        end else if (state == link_pkg::MAIN_IDLE || state == link_pkg::MAIN_WAIT) begin
            read_btype <= link_pkg::BAG_INIT;
            read_bdata <= '0;
        end else if (state == link_pkg::READ_TAKE) begin
            read_btype <= rx_btype;
            read_bdata <= rx_bdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_idx <= '0;
            data_idx   <= '0;
        end else if (state == link_pkg::READ_TAKE) begin
            if (rx_btype == link_pkg::BAG_DIDX) device_idx <= rx_bdata;
            if (rx_btype == link_pkg::BAG_DDIDX) data_idx <= rx_bdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_btype <= link_pkg::BAG_INIT;
        end else begin
            case (state)
                link_pkg::MAIN_IDLE, link_pkg::MAIN_WAIT: tx_btype <= link_pkg::BAG_INIT;
                link_pkg::SEND_PDATA0: tx_btype <= send_btype;
                link_pkg::SEND_PDATA1: begin
                    // retry toggles DATA0, anything else goes again as is.
                    if (tx_btype == link_pkg::BAG_DATA0) tx_btype <= link_pkg::BAG_DATA1;
                end
                link_pkg::SEND_PACK: tx_btype <= link_pkg::BAG_ACK;
                link_pkg::SEND_PNAK: tx_btype <= link_pkg::BAG_NAK;
                default: tx_btype <= tx_btype;
            endcase
        end
    end

endmodule

/* link_pkg.sv */
`include "link_settings.svh"

package link_pkg;

    // bag codes as they travel on the wire.
    typedef enum logic [`LINK_TYPE_BITS-1:0] {
        BAG_INIT   = 4'b0000,
        BAG_ACK    = 4'b0001,
        BAG_NAK    = 4'b0010,
        BAG_STALL  = 4'b0011,
        BAG_DIDX   = 4'b0101,
        BAG_DPARAM = 4'b0110,
        BAG_DDIDX  = 4'b0111,
        BAG_DLINK  = 4'b1000,
        BAG_DTYPE  = 4'b1001,
        BAG_DTEMP  = 4'b1010,
        BAG_DHEAD  = 4'b1100,
        BAG_DATA0  = 4'b1101,
        BAG_DATA1  = 4'b1110
    } bag_type_e;

    // controller states, upper nibble gives the group.
    typedef enum logic [7:0] {
        MAIN_IDLE   = 8'h00,
        MAIN_WAIT   = 8'h01,
        SEND_DATA   = 8'h10,
        SEND_ACK    = 8'h11,
        SEND_NAK    = 8'h12,
        SEND_DONE   = 8'h13,
        SEND_PDATA0 = 8'h14,
        SEND_PDATA1 = 8'h15,
        SEND_PACK   = 8'h16,
        SEND_PNAK   = 8'h17,
        SEND_WNAK   = 8'h18,
        RECV_WAIT   = 8'h20,
        RECV_TAKE   = 8'h21,
        RECV_DONE   = 8'h22,
        READ_DATA   = 8'h40,
        READ_TAKE   = 8'h41,
        READ_DONE   = 8'h42,
        READ_WAIT   = 8'h43
    } cs_state_e;

endpackage

/* link_props.sv */
module link_props (
    input logic clk,
    input logic rst,
    input logic fd_send,
    input logic fs_read,
    input logic fs_tx,
    input logic fd_tx,
    input logic fs_rx,
    input logic fd_rx
);

    // send and read answers never meet, not even back to back.
    host_exclusive: assert property (@(posedge clk) disable iff (rst)
        !((fd_send || $past(fd_send)) && (fs_read || $past(fs_read))))
        else $error("fd_send and fs_read high together");

    tx_request_held: assert property (@(posedge clk) disable iff (rst)
        fs_tx && !fd_tx |=> fs_tx)
        else $error("fs_tx dropped before fd_tx");

    // fd_rx may outlive fs_rx by one cycle.
    rx_done_follows: assert property (@(posedge clk) disable iff (rst)
        fd_rx |-> fs_rx || $fell(fs_rx))
        else $error("fd_rx high without fs_rx");

endmodule

bind link_cs link_props u_props (
    .clk     (clk),
    .rst     (rst),
    .fd_send (fd_send),
    .fs_read (fs_read),
    .fs_tx   (fs_tx),
    .fd_tx   (fd_tx),
    .fs_rx   (fs_rx),
    .fd_rx   (fd_rx)
);

/* link_settings.svh */
`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// clocks per serial bit.
`define LINK_BIT_CYCLES 4
`define LINK_TYPE_BITS 4
`define LINK_DATA_BITS 4

`endif

/* link_tb.sv */
`include "link_settings.svh"

module link_tb;

    localparam int BIT_CYCLES = `LINK_BIT_CYCLES;
    localparam int FIELDS = 9;
    localparam int MAX_RECORDS = 32;
    localparam int HS_TIMEOUT = 100 * BIT_CYCLES;

    logic                       clk;
    logic                       rst;
    logic                       rx_line;
    logic                       tx_line;
    logic                       fs_send;
    link_pkg::bag_type_e        send_btype;
    logic                       fd_send;
    logic                       fs_read;
    logic                       fd_read;
    link_pkg::bag_type_e        read_btype;
    logic [`LINK_DATA_BITS-1:0] read_bdata;
    logic [`LINK_DATA_BITS-1:0] device_idx;
    logic [`LINK_DATA_BITS-1:0] data_idx;

    // one hex digit per field, nine fields per record.
    logic [3:0]  vec [0:FIELDS*MAX_RECORDS-1];
    logic [31:0] rng;

    link_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .rx_line    (rx_line),
        .tx_line    (tx_line),
        .fs_send    (fs_send),
        .send_btype (send_btype),
        .fd_send    (fd_send),
        .fs_read    (fs_read),
        .fd_read    (fd_read),
        .read_btype (read_btype),
        .read_bdata (read_bdata),
        .device_idx (device_idx),
        .data_idx   (data_idx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [3:0] expected,
                         input logic [3:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("** Error: %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    // idle time in whole bit periods.
    task automatic idle_gap();
        rng = xorshift32(rng);
        repeat (int'(rng[1:0]) * BIT_CYCLES) @(negedge clk);
    endtask

    task automatic send_frame(input logic [3:0] btype, input logic [3:0] bdata,
                              input logic stop);
        logic [9:0] bits;
        bits = {stop, bdata, btype, 1'b0};
        @(negedge clk);
        idle_gap();
        for (int i = 0; i < 10; i++) begin
            rx_line = bits[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rx_line = 1'b1;
    endtask

    // peer side decoder, samples each bit in its middle.
    task automatic read_frame(input string name, output logic [3:0] btype);
        int n;
        n = 0;
        while (tx_line) begin
            @(negedge clk);
            n++;
            if (n > HS_TIMEOUT) begin
                stop_on_failure({name, ": no frame started on tx_line"});
            end
        end
        repeat (BIT_CYCLES / 2) @(negedge clk);
        check({name, " start bit"}, 4'h0, 4'(tx_line));
        for (int i = 0; i < 4; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            btype[i] = tx_line;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check({name, " stop bit"}, 4'h1, 4'(tx_line));
    endtask

    task automatic wait_fd_send(input logic level, input string name);
        int n;
        n = 0;
        while (fd_send != level) begin
            @(negedge clk);
            n++;
            if (level && !tx_line) begin
                stop_on_failure({name, ": extra frame on tx_line before fd_send"});
            end
            if (n > HS_TIMEOUT) begin
                stop_on_failure({name, ": fd_send handshake stalled"});
            end
        end
    endtask

    task automatic wait_fs_read(input logic level, input string name);
        int n;
        n = 0;
        while (fs_read != level) begin
            @(negedge clk);
            n++;
            if (n > HS_TIMEOUT) begin
                stop_on_failure({name, ": fs_read handshake stalled"});
            end
        end
    endtask

    task automatic run_send(input int rec);
        int         base;
        logic [3:0] btype;
        string      name;
        base = rec * FIELDS;
        name = $sformatf("vector %0d send", rec);
        @(negedge clk);
        send_btype = link_pkg::bag_type_e'(vec[base+1]);
        fs_send = 1'b1;
        // one frame per peer answer, the last answer is the ACK.
        for (int i = 0; i < int'(vec[base+2]); i++) begin
            read_frame($sformatf("%s frame %0d", name, i), btype);
            check($sformatf("%s frame %0d type", name, i), vec[base+6+i], btype);
            send_frame(vec[base+3+i], 4'h0, 1'b1);
        end
        wait_fd_send(1'b1, name);
        // answer stays up while the request is held.
        repeat (BIT_CYCLES) @(negedge clk);
        check({name, " fd_send held"}, 4'h1, 4'(fd_send));
        fs_send = 1'b0;
        wait_fd_send(1'b0, name);
    endtask

    task automatic run_peer(input int rec);
        int         base;
        logic [3:0] btype;
        string      name;
        base = rec * FIELDS;
        name = $sformatf("vector %0d peer", rec);
        send_frame(vec[base+1], vec[base+2], 1'b1);
        read_frame(name, btype);
        check({name, " answer type"}, vec[base+3], btype);
        wait_fs_read(1'b1, name);
        check({name, " read_btype"}, vec[base+4], read_btype);
        check({name, " read_bdata"}, vec[base+5], read_bdata);
        check({name, " device_idx"}, vec[base+6], device_idx);
        check({name, " data_idx"}, vec[base+7], data_idx);
        fd_read = 1'b1;
        wait_fs_read(1'b0, name);
        fd_read = 1'b0;
    endtask

    task automatic run_bad_stop(input int rec);
        int    base;
        string name;
        base = rec * FIELDS;
        name = $sformatf("vector %0d bad stop", rec);
        send_frame(vec[base+1], vec[base+2], 1'b0);
        // the frame must die quietly.
        for (int i = 0; i < 20 * BIT_CYCLES; i++) begin
            @(negedge clk);
            check({name, " tx_line idle"}, 4'h1, 4'(tx_line));
        end
        check({name, " fs_read"}, 4'h0, 4'(fs_read));
    endtask

    initial begin
        int   rec;
        logic running;
        rst = 1'b1;
        rx_line = 1'b1;
        fs_send = 1'b0;
        send_btype = link_pkg::BAG_INIT;
        fd_read = 1'b0;
        rng = 32'd78185;
        $readmemh("link_vectors.txt", vec);
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("reset fd_send", 4'h0, 4'(fd_send));
        check("reset fs_read", 4'h0, 4'(fs_read));
        check("reset tx_line", 4'h1, 4'(tx_line));
        check("reset device_idx", 4'h0, device_idx);
        check("reset data_idx", 4'h0, data_idx);
        rec = 0;
        running = 1'b1;
        while (running) begin
            if (rec >= MAX_RECORDS) begin
                stop_on_failure("link_vectors.txt has no end record");
            end
            idle_gap();
            case (vec[rec*FIELDS])
                4'h0: running = 1'b0;
                4'h1: run_send(rec);
                4'h2: run_peer(rec);
                4'h3: run_bad_stop(rec);
                default: stop_on_failure($sformatf("record %0d of link_vectors.txt is unreadable",
                                                   rec));
            endcase
            rec++;
        end
        if (rec < 2) begin
            stop_on_failure("no transactions read from link_vectors.txt");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* link_top.sv */
`include "link_settings.svh"

module link_top #(
    parameter int BIT_CYCLES = `LINK_BIT_CYCLES
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx_line,
    output logic                       tx_line,
    input  logic                       fs_send,
    input  link_pkg::bag_type_e        send_btype,
    output logic                       fd_send,
    output logic                       fs_read,
    input  logic                       fd_read,
    output link_pkg::bag_type_e        read_btype,
    output logic [`LINK_DATA_BITS-1:0] read_bdata,
    output logic [`LINK_DATA_BITS-1:0] device_idx,
    output logic [`LINK_DATA_BITS-1:0] data_idx
);

    // transmit handshake.
    logic                       fs_tx;
    logic                       fd_tx;
    link_pkg::bag_type_e        tx_btype;
    // receive handshake.
    logic                       fs_rx;
    logic                       fd_rx;
    link_pkg::bag_type_e        rx_btype;
    logic [`LINK_DATA_BITS-1:0] rx_bdata;

    link_cs u_cs (
        .clk        (clk),
        .rst        (rst),
        .fs_send    (fs_send),
        .send_btype (send_btype),
        .fd_send    (fd_send),
        .fs_read    (fs_read),
        .fd_read    (fd_read),
        .read_btype (read_btype),
        .read_bdata (read_bdata),
        .device_idx (device_idx),
        .data_idx   (data_idx),
        .fs_tx      (fs_tx),
        .fd_tx      (fd_tx),
        .tx_btype   (tx_btype),
        .fs_rx      (fs_rx),
        .fd_rx      (fd_rx),
        .rx_btype   (rx_btype),
        .rx_bdata   (rx_bdata)
    );

    bag_tx #(.BIT_CYCLES(BIT_CYCLES)) u_tx (
        .clk      (clk),
        .rst      (rst),
        .fs_tx    (fs_tx),
        .tx_btype (tx_btype),
        .fd_tx    (fd_tx),
        .tx_line  (tx_line)
    );

    bag_rx #(.BIT_CYCLES(BIT_CYCLES)) u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx_line  (rx_line),
        .fd_rx    (fd_rx),
        .fs_rx    (fs_rx),
        .rx_btype (rx_btype),
        .rx_bdata (rx_bdata)
    );

endmodule

/* link_vectors.txt */
// kind type arg x0 x1 x2 y0 y1 y2, kind 1 send, 2 peer bag, 3 bad stop, 0 end.
// send: arg answer count, x peer answers, y expected frame types on tx_line.
// peer: arg data, x0 answer frame, x1 read_btype, x2 read_bdata, y0 device_idx, y1 data_idx.
// DATA0 acked at once.
1 d 1 1 0 0 d 0 0
// DATA0 nak then ack, resent as DATA1.
1 d 2 2 1 0 d e 0
// DTYPE nak then ack, resent unchanged.
1 9 2 2 1 0 9 9 0
// two naks, DATA1 stays DATA1.
1 d 3 2 2 1 d e e
1 e 1 1 0 0 e 0 0
// index and parameter bags.
2 5 3 1 5 3 3 0 0
2 7 a 1 7 a 3 a 0
2 6 f 1 6 f 3 a 0
// refused bags.
2 d 4 2 0 0 3 a 0
2 1 7 2 0 0 3 a 0
2 c 2 2 0 0 3 a 0
// low stop bit, then a good DIDX.
3 5 9 0 0 0 0 0 0
2 5 c 1 5 c c a 0
1 6 1 1 0 0 6 0 0
0 0 0 0 0 0 0 0 0

/* run_sim.sh */
#!/usr/bin/env bash
# builds the link testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module link_tb -o link_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/link_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0
